//--- source/loader_pkg.sv
// Host download definitions
// Index codes and cheat record layout

package loader_pkg;

	////////////////////
	// Host download bus
	////////////////////

	localparam int IOCTL_ADDR_WIDTH = 25;
	localparam int IOCTL_INDEX_WIDTH = 8;

	// One 16-bit data word from the host
	typedef logic [15:0] ioctl_word_t;

	// Cheat files use the all-ones index
	localparam logic [IOCTL_INDEX_WIDTH-1:0] CODE_INDEX = '1;

	// Low six index bits up to this value select a cartridge
	localparam logic [5:0] CART_INDEX_MAX = 6'd1;

	////////////////////
	// Cheat record
	////////////////////

	localparam int CHEAT_FIELD_WIDTH = 32;
	localparam int CHEAT_HALF_WIDTH = CHEAT_FIELD_WIDTH / 2;

	// Flags on top and replace at the bottom
	localparam int CHEAT_FLAGS_LSB = 3 * CHEAT_FIELD_WIDTH;
	localparam int CHEAT_ADDRESS_LSB = 2 * CHEAT_FIELD_WIDTH;
	localparam int CHEAT_COMPARE_LSB = CHEAT_FIELD_WIDTH;
	localparam int CHEAT_REPLACE_LSB = 0;

	// Byte offset of a word inside one eight-word record
	localparam int CHEAT_OFFSET_WIDTH = 4;
	localparam logic [CHEAT_OFFSET_WIDTH-1:0] CHEAT_LAST_OFFSET = 4'd14;

	// Flags, address, compare, replace
	typedef logic [4*CHEAT_FIELD_WIDTH-1:0] cheat_code_t;

endpackage

//--- source/cd_pkg.sv
// CD data file definitions

package cd_pkg;

	// Width of the byte length in the header word
	localparam int CD_LEN_WIDTH = 15;

	typedef logic [7:0] cd_byte_t;

	////////////////////
	// CD data word
	////////////////////

	// First word of a file
	typedef struct packed {
		logic data_mode;
		logic [CD_LEN_WIDTH-1:0] len;
	} cd_header_t;

	// Every later word with its low byte going out first
	typedef struct packed {
		cd_byte_t high;
		cd_byte_t low;
	} cd_data_t;

	// Same 16 bits read by position in the file
	typedef union packed {
		cd_header_t header;
		cd_data_t data;
	} cd_word_t;

endpackage

//--- source/download_decode.sv
// Host download decoder

`timescale 1ns/1ps

module download_decode #(
	parameter logic [5:0] CD_DATA_INDEX = 6'd2
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ioctl_download,
	input  logic [loader_pkg::IOCTL_INDEX_WIDTH-1:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] ioctl_addr,
	input  loader_pkg::ioctl_word_t ioctl_dout,
	output logic cart_download,
	output logic cd_start,
	output logic cd_word_wr,
	output logic code_word_wr,
	output loader_pkg::ioctl_word_t word,
	output logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] word_addr,
	output logic cheat_clear
);
	import loader_pkg::*;

	logic code_download;
	logic cd_download;

	// Sampled host write
	logic wr_q;
	logic cart_q;
	logic code_q;
	logic cd_q;
	logic cd_prev;
	ioctl_word_t dout_q;
	logic [IOCTL_ADDR_WIDTH-1:0] addr_q;

	// Index classes
	assign code_download = ioctl_download & (ioctl_index == CODE_INDEX);
	assign cart_download = ioctl_download & (ioctl_index[5:0] <= CART_INDEX_MAX);
	assign cd_download = ioctl_download & (ioctl_index[5:0] == CD_DATA_INDEX);

	////////////////////
	// Sample stage
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_q <= 1'b0;
			cart_q <= 1'b0;
			code_q <= 1'b0;
			cd_q <= 1'b0;
			cd_prev <= 1'b0;
		end else begin
			wr_q <= ioctl_wr;
			cart_q <= cart_download;
			code_q <= code_download;
			cd_q <= cd_download;
			cd_prev <= cd_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		dout_q <= ioctl_dout;
		addr_q <= ioctl_addr;
	end

	////////////////////
	// Strobe stage
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cd_start <= 1'b0;
			cd_word_wr <= 1'b0;
			code_word_wr <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			// Rising edge of a CD data download
			cd_start <= cd_q & ~cd_prev;
			cd_word_wr <= wr_q & cd_q;
			code_word_wr <= wr_q & code_q;
			// First word of a cartridge or code file wipes the cheat engine
			cheat_clear <= wr_q & (cart_q | code_q) & (addr_q == '0);
		end
	end

	always_ff @(posedge clk_sys) begin
		word <= dout_q;
		word_addr <= addr_q;
	end

endmodule

//--- source/cd_sector_header.sv
// CD header parser and byte counter

`timescale 1ns/1ps

module cd_sector_header (
	input  logic clk_sys,
	input  logic reset,
	input  logic cd_start,
	input  logic cd_word_wr,
	input  loader_pkg::ioctl_word_t word,
	output logic word_valid,
	output cd_pkg::cd_word_t data_word,
	output logic single_byte,
	output logic data_mode
);
	import cd_pkg::*;

	cd_word_t in_word;
	logic header_seen;
	logic header_pending;
	logic accept;
	logic last_odd;
	logic [CD_LEN_WIDTH-1:0] data_len;
	logic [CD_LEN_WIDTH-1:0] byte_cnt;
	logic [CD_LEN_WIDTH-1:0] bytes_left;

	assign in_word = word;

	// A start in the same cycle as a write makes that write the header
	assign header_pending = cd_start | ~header_seen;

	// Data word inside the announced length
	assign accept = cd_word_wr & ~header_pending & (byte_cnt < data_len);

	assign bytes_left = data_len - byte_cnt;
	assign last_odd = (bytes_left == CD_LEN_WIDTH'(1));

	////////////////////
	// Header and count
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			header_seen <= 1'b0;
			data_len <= '0;
			byte_cnt <= '0;
			data_mode <= 1'b0;
			word_valid <= 1'b0;
			single_byte <= 1'b0;
		end else begin
			word_valid <= 1'b0;

			if (cd_start) begin
				header_seen <= 1'b0;
				data_len <= '0;
				byte_cnt <= '0;
			end

			if (cd_word_wr && header_pending) begin
				header_seen <= 1'b1;
				data_len <= in_word.header.len;
				data_mode <= in_word.header.data_mode;
				byte_cnt <= '0;
			end else if (accept) begin
				word_valid <= 1'b1;
				single_byte <= last_odd;
				// Odd tail carries only its low byte
				byte_cnt <= byte_cnt + (last_odd ? CD_LEN_WIDTH'(1) : CD_LEN_WIDTH'(2));
			end
			// Surplus words past the length fall through here
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			data_word.data <= in_word.data;
		end
	end

endmodule

//--- source/cd_byte_writer.sv
// CD byte write sequencer

`timescale 1ns/1ps

module cd_byte_writer (
	input  logic clk_sys,
	input  logic reset,
	input  logic word_valid,
	input  cd_pkg::cd_word_t data_word,
	input  logic single_byte,
	input  logic data_mode,
	output logic cd_wr,
	output cd_pkg::cd_byte_t cd_data,
	output logic cd_dm
);
	import cd_pkg::*;

	localparam logic [1:0] PHASE_IDLE = 2'd0;
	localparam logic [1:0] PHASE_GAP = 2'd1;
	localparam logic [1:0] PHASE_HIGH = 2'd2;

	logic [1:0] phase;
	logic skip_high;
	cd_byte_t high_byte;

	// Low byte, one idle cycle, then high byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase <= PHASE_IDLE;
			cd_wr <= 1'b0;
			cd_dm <= 1'b0;
			skip_high <= 1'b0;
		end else begin
			case (phase)
				PHASE_IDLE: begin
					cd_wr <= word_valid;
					if (word_valid) begin
						phase <= PHASE_GAP;
						skip_high <= single_byte;
						cd_dm <= data_mode;
					end
				end
				PHASE_GAP: begin
					cd_wr <= 1'b0;
					phase <= PHASE_HIGH;
				end
				PHASE_HIGH: begin
					// No strobe for the last odd byte
					cd_wr <= ~skip_high;
					phase <= PHASE_IDLE;
				end
				default: begin
					cd_wr <= 1'b0;
					phase <= PHASE_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (phase == PHASE_IDLE && word_valid) begin
			cd_data <= data_word.data.low;
			high_byte <= data_word.data.high;
		end else if (phase == PHASE_HIGH) begin
			cd_data <= high_byte;
		end
	end

endmodule

//--- source/cheat_code_assembler.sv
// Cheat record assembler

`timescale 1ns/1ps

module cheat_code_assembler (
	input  logic clk_sys,
	input  logic reset,
	input  logic code_word_wr,
	input  loader_pkg::ioctl_word_t word,
	input  logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] word_addr,
	output loader_pkg::cheat_code_t cheat_code,
	output logic cheat_load
);
	import loader_pkg::*;

	logic [CHEAT_OFFSET_WIDTH-1:0] offset;

	// Position of the word inside its record
	assign offset = word_addr[CHEAT_OFFSET_WIDTH-1:0];

	// Last half of the replace field completes the record
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_load <= 1'b0;
		end else begin
			cheat_load <= code_word_wr & (offset == CHEAT_LAST_OFFSET);
		end
	end

	////////////////////
	// Field placement
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (code_word_wr) begin
			case (offset)
				4'd0: cheat_code[CHEAT_FLAGS_LSB +: CHEAT_HALF_WIDTH] <= word;
				4'd2: cheat_code[CHEAT_FLAGS_LSB + CHEAT_HALF_WIDTH +: CHEAT_HALF_WIDTH] <= word;
				4'd4: cheat_code[CHEAT_ADDRESS_LSB +: CHEAT_HALF_WIDTH] <= word;
				4'd6: cheat_code[CHEAT_ADDRESS_LSB + CHEAT_HALF_WIDTH +: CHEAT_HALF_WIDTH] <= word;
				4'd8: cheat_code[CHEAT_COMPARE_LSB +: CHEAT_HALF_WIDTH] <= word;
				4'd10: cheat_code[CHEAT_COMPARE_LSB + CHEAT_HALF_WIDTH +: CHEAT_HALF_WIDTH] <= word;
				4'd12: cheat_code[CHEAT_REPLACE_LSB +: CHEAT_HALF_WIDTH] <= word;
				CHEAT_LAST_OFFSET: begin
					cheat_code[CHEAT_REPLACE_LSB + CHEAT_HALF_WIDTH +: CHEAT_HALF_WIDTH] <= word;
				end
				default: begin
					// Odd offsets carry nothing
				end
			endcase
		end
	end

endmodule

//--- source/media_loader_top.sv
// Media loader top level

`timescale 1ns/1ps

module media_loader_top #(
	parameter logic [5:0] CD_DATA_INDEX = 6'd2
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ioctl_download,
	input  logic [loader_pkg::IOCTL_INDEX_WIDTH-1:0] ioctl_index,
	input  logic ioctl_wr,
	input  logic [loader_pkg::IOCTL_ADDR_WIDTH-1:0] ioctl_addr,
	input  loader_pkg::ioctl_word_t ioctl_dout,
	output logic cart_download,
	output logic cd_wr,
	output cd_pkg::cd_byte_t cd_data,
	output logic cd_dm,
	output loader_pkg::cheat_code_t cheat_code,
	output logic cheat_load,
	output logic cheat_clear
);
	import loader_pkg::*;
	import cd_pkg::*;

	// Decoder outputs
	logic cd_start;
	logic cd_word_wr;
	logic code_word_wr;
	ioctl_word_t word;
	logic [IOCTL_ADDR_WIDTH-1:0] word_addr;

	// Header parser outputs
	logic word_valid;
	cd_word_t data_word;
	logic single_byte;
	logic data_mode;

	download_decode #(
		.CD_DATA_INDEX(CD_DATA_INDEX)
	) download_decode_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.cart_download(cart_download),
		.cd_start(cd_start),
		.cd_word_wr(cd_word_wr),
		.code_word_wr(code_word_wr),
		.word(word),
		.word_addr(word_addr),
		.cheat_clear(cheat_clear)
	);

	cd_sector_header cd_sector_header_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.cd_start(cd_start),
		.cd_word_wr(cd_word_wr),
		.word(word),
		.word_valid(word_valid),
		.data_word(data_word),
		.single_byte(single_byte),
		.data_mode(data_mode)
	);

	cd_byte_writer cd_byte_writer_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.word_valid(word_valid),
		.data_word(data_word),
		.single_byte(single_byte),
		.data_mode(data_mode),
		.cd_wr(cd_wr),
		.cd_data(cd_data),
		.cd_dm(cd_dm)
	);

	cheat_code_assembler cheat_code_assembler_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.code_word_wr(code_word_wr),
		.word(word),
		.word_addr(word_addr),
		.cheat_code(cheat_code),
		.cheat_load(cheat_load)
	);

endmodule

//--- bench/media_loader_vectors.svh
// Media loader stimulus and expected values

`ifndef MEDIA_LOADER_VECTORS_SVH
`define MEDIA_LOADER_VECTORS_SVH

// One host write, or one idle step when wr is low
typedef struct packed {
	logic wr;
	logic download;
	logic [IOCTL_INDEX_WIDTH-1:0] index;
	logic [IOCTL_ADDR_WIDTH-1:0] addr;
	ioctl_word_t dout;
	logic [1:0] nbytes;
	logic [7:0] first_byte;
	logic [7:0] second_byte;
	logic dm;
	logic clear;
	logic cart;
	logic load;
} vector_t;

// Record built from the eight code words below
localparam cheat_code_t EXPECTED_CHEAT =
	{32'h80000f01, 32'h00124567, 32'hcd0000ab, 32'h77660099};

task automatic load_table();
	// wr, download, index, addr, dout, bytes out, first, second, dm, clear, cart, load
	// Even-length CD file in mode 0
	add_row(1, 1, 'h02, 'h0, 'h0006, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'h02, 'h2, 'ha511, 2, 'h11, 'ha5, 0, 0, 0, 0);
	add_row(1, 1, 'h02, 'h4, 'h3c22, 2, 'h22, 'h3c, 0, 0, 0, 0);
	add_row(1, 1, 'h02, 'h6, 'h0f7e, 2, 'h7e, 'h0f, 0, 0, 0, 0);
	add_row(0, 0, 'h02, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
	// Odd length with mode bit, then a surplus word
	add_row(1, 1, 'h02, 'h0, 'h8003, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'h02, 'h2, 'h5a96, 2, 'h96, 'h5a, 1, 0, 0, 0);
	add_row(1, 1, 'h02, 'h4, 'hee47, 1, 'h47, 'h00, 1, 0, 0, 0);
	add_row(1, 1, 'h02, 'h6, 'h1234, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(0, 0, 'h02, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
	// Partial file, then a restart
	add_row(1, 1, 'h02, 'h0, 'h0008, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'h02, 'h2, 'hbeef, 2, 'hef, 'hbe, 0, 0, 0, 0);
	add_row(0, 0, 'h02, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'h02, 'h0, 'h8002, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'h02, 'h2, 'hc301, 2, 'h01, 'hc3, 1, 0, 0, 0);
	add_row(0, 0, 'h02, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
	// Cheat record with offsets out of order
	add_row(1, 1, 'hff, 'h6, 'h0012, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'hff, 'h0, 'h0f01, 0, 'h00, 'h00, 0, 1, 0, 0);
	add_row(1, 1, 'hff, 'hc, 'h0099, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'hff, 'h2, 'h8000, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'hff, 'ha, 'hcd00, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'hff, 'h4, 'h4567, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'hff, 'h8, 'h00ab, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'hff, 'he, 'h7766, 0, 'h00, 'h00, 0, 0, 0, 1);
	add_row(0, 0, 'hff, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
	// Cartridge indexes and one that is neither
	add_row(1, 1, 'h00, 'h0, 'h1234, 0, 'h00, 'h00, 0, 1, 1, 0);
	add_row(1, 1, 'h00, 'h2, 'h5678, 0, 'h00, 'h00, 0, 0, 1, 0);
	add_row(0, 0, 'h00, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'h41, 'h0, 'h9abc, 0, 'h00, 'h00, 0, 1, 1, 0);
	add_row(0, 0, 'h41, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(1, 1, 'h05, 'h0, 'hdef0, 0, 'h00, 'h00, 0, 0, 0, 0);
	add_row(0, 0, 'h05, 'h0, 'h0000, 0, 'h00, 'h00, 0, 0, 0, 0);
endtask

`endif

//--- bench/media_loader_tb.sv
// Media loader testbench

`timescale 1ns/1ps

module media_loader_tb;
	import loader_pkg::*;

	localparam int CLK_HALF = 10;
	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 1;
	localparam int ROW_SPACING = 6;
	localparam int DRAIN_CYCLES = 10;

	logic clk_sys = 1'b0;
	logic reset;
	logic ioctl_download;
	logic [IOCTL_INDEX_WIDTH-1:0] ioctl_index;
	logic ioctl_wr;
	logic [IOCTL_ADDR_WIDTH-1:0] ioctl_addr;
	ioctl_word_t ioctl_dout;
	logic cart_download;
	logic cd_wr;
	logic [7:0] cd_data;
	logic cd_dm;
	cheat_code_t cheat_code;
	logic cheat_load;
	logic cheat_clear;

	`include "media_loader_vectors.svh"

	vector_t vectors[$];

	// Expected event streams
	logic [7:0] exp_bytes[$];
	logic exp_dm[$];
	int exp_clears = 0;
	int exp_loads = 0;

	// Observed event streams
	logic [7:0] byte_q[$];
	logic dm_q[$];
	cheat_code_t load_q[$];
	int clear_count = 0;
	int early_pulses = 0;
	logic writes_started = 1'b0;

	int check_count = 0;
	int error_count = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	media_loader_top #(
		.CD_DATA_INDEX(6'd2)
	) media_loader_top_inst (
		.clk_sys(clk_sys),
		.reset(reset),
		.ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index),
		.ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout),
		.cart_download(cart_download),
		.cd_wr(cd_wr),
		.cd_data(cd_data),
		.cd_dm(cd_dm),
		.cheat_code(cheat_code),
		.cheat_load(cheat_load),
		.cheat_clear(cheat_clear)
	);

	always #CLK_HALF clk_sys = ~clk_sys;

	task automatic add_row(input int wr, input int download, input int index, input int addr,
		input int dout, input int nbytes, input int first_byte, input int second_byte,
		input int dm, input int clear, input int cart, input int load);
		vector_t v;
		v.wr = (wr != 0);
		v.download = (download != 0);
		v.index = IOCTL_INDEX_WIDTH'(index);
		v.addr = IOCTL_ADDR_WIDTH'(addr);
		v.dout = 16'(dout);
		v.nbytes = 2'(nbytes);
		v.first_byte = 8'(first_byte);
		v.second_byte = 8'(second_byte);
		v.dm = (dm != 0);
		v.clear = (clear != 0);
		v.cart = (cart != 0);
		v.load = (load != 0);
		vectors.push_back(v);
	endtask

	task automatic compare(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
		end
	endtask

	// Byte order and event counts straight from the table
	task automatic build_expected();
		foreach (vectors[i]) begin
			if (vectors[i].nbytes >= 2'd1) begin
				exp_bytes.push_back(vectors[i].first_byte);
				exp_dm.push_back(vectors[i].dm);
			end
			if (vectors[i].nbytes >= 2'd2) begin
				exp_bytes.push_back(vectors[i].second_byte);
				exp_dm.push_back(vectors[i].dm);
			end
			if (vectors[i].clear) exp_clears++;
			if (vectors[i].load) exp_loads++;
		end
	endtask

	task automatic apply_row(input vector_t v);
		@(posedge clk_sys);
		#DRIVE_DELAY;
		ioctl_download = v.download;
		ioctl_index = v.index;
		ioctl_addr = v.addr;
		ioctl_dout = v.dout;
		ioctl_wr = v.wr;
		if (v.wr) writes_started = 1'b1;
		// Cartridge flag follows the inputs directly
		@(negedge clk_sys);
		compare("cart_download", 128'(cart_download), 128'(v.cart));
		@(posedge clk_sys);
		#DRIVE_DELAY;
		ioctl_wr = 1'b0;
		repeat (ROW_SPACING - 2) @(posedge clk_sys);
	endtask

	////////////////////
	// Output monitor
	////////////////////

	always @(negedge clk_sys) begin
		if (!writes_started) begin
			if (cd_wr === 1'b1 || cheat_load === 1'b1 || cheat_clear === 1'b1) early_pulses++;
		end else begin
			if (cd_wr) begin
				byte_q.push_back(cd_data);
				dm_q.push_back(cd_dm);
			end
			if (cheat_load) load_q.push_back(cheat_code);
			if (cheat_clear) clear_count++;
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;

		load_table();
		build_expected();
		cycle_limit = 2 * vectors.size() * ROW_SPACING + 100;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		#DRIVE_DELAY;
		reset = 1'b0;
		// Quiet stretch before the first host write
		repeat (4) @(posedge clk_sys);

		foreach (vectors[i]) apply_row(vectors[i]);
		repeat (DRAIN_CYCLES) @(posedge clk_sys);

		compare("pulses before first write", 128'(early_pulses), 128'(0));
		compare("cd_wr count", 128'(byte_q.size()), 128'(exp_bytes.size()));
		for (int i = 0; i < exp_bytes.size() && i < byte_q.size(); i++) begin
			compare("cd_data", 128'(byte_q[i]), 128'(exp_bytes[i]));
			compare("cd_dm", 128'(dm_q[i]), 128'(exp_dm[i]));
		end
		compare("cheat_clear count", 128'(clear_count), 128'(exp_clears));
		compare("cheat_load count", 128'(load_q.size()), 128'(exp_loads));
		foreach (load_q[i]) compare("cheat_code", load_q[i], EXPECTED_CHEAT);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
+incdir+bench
source/loader_pkg.sv
source/cd_pkg.sv
source/download_decode.sv
source/cd_sector_header.sv
source/cd_byte_writer.sv
source/cheat_code_assembler.sv
source/media_loader_top.sv
bench/media_loader_tb.sv

//--- Makefile
# Verilator build for the media loader

VERILATOR ?= verilator
TOP ?= media_loader_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= TEST OK
VFLAGS ?= --timing

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
